// File: verilog/tcp_shell_pkg.sv
// shared constants for the tcp offload shell
// metadata channel widths and indices, memory command field positions
// default data width and rx buffer depth
package tcp_shell_pkg;

  // application metadata slice bank
  localparam int meta_w = 88;  // widest channel, notifications
  localparam int n_meta = 9;

  // slot of each channel in the slice bank
  localparam int ch_listen_port   = 0;
  localparam int ch_listen_status = 1;
  localparam int ch_open_conn     = 2;
  localparam int ch_open_status   = 3;
  localparam int ch_close_conn    = 4;
  localparam int ch_notify        = 5;
  localparam int ch_read_pkg      = 6;
  localparam int ch_rx_meta       = 7;
  localparam int ch_tx_meta       = 8;

  // payload bits the core really uses per channel, indexed as above
  localparam int meta_field_w [n_meta] = '{16, 8, 48, 24, 16, 88, 32, 16, 32};

  // memory command word from the core
  localparam int cmd_w        = 72;
  localparam int cmd_addr_lsb = 32;  // 32-bit address field
  localparam int cmd_addr_msb = 63;
  localparam int cmd_len_msb  = 22;  // length field starts at bit 0
  localparam int mem_addr_w   = 64;
  localparam int mem_len_w    = 32;

  localparam int cnt_w = 16;  // occupancy and read counters

  localparam int default_data_w    = 512;
  localparam int default_buf_depth = 1024;

endpackage

// File: verilog/meta_reg_slice.sv
// two-entry skid buffer for one application metadata channel
// registered valid and data toward the consumer, registered ready toward the producer
`timescale 1ns/1ps

module meta_reg_slice (
  input  logic                            net_clk,
  input  logic                            net_aresetn,
  input  logic                            in_valid,
  output logic                            in_ready,
  input  logic [tcp_shell_pkg::meta_w-1:0] in_data,
  output logic                            out_valid,
  input  logic                            out_ready,
  output logic [tcp_shell_pkg::meta_w-1:0] out_data
);

  logic                            skid_valid;  // second entry holds a word
  logic [tcp_shell_pkg::meta_w-1:0] skid_data;
  logic                            accept;
  logic                            main_free;  // main reg empty or draining

  assign in_ready  = !skid_valid;  // only skid full means both full
  assign accept    = in_valid && in_ready;
  assign main_free = !out_valid || out_ready;

  // control state
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (main_free) begin
        if (skid_valid) begin
          out_valid  <= 1'b1;  // skid moves up, no accept this cycle
          skid_valid <= 1'b0;
        end else begin
          out_valid <= accept;  // straight into main
        end
      end else if (accept) begin
        skid_valid <= 1'b1;  // main stalled, park in skid
      end
    end
  end

  // payload
  always_ff @(posedge net_clk) begin
    if (main_free) begin
      if (skid_valid) begin
        out_data <= skid_data;  // oldest word first
      end else if (accept) begin
        out_data <= in_data;
      end
    end
    if (!main_free && accept) begin
      skid_data <= in_data;
    end
  end

  // stalled word must not change under the consumer
  a_out_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

  // no third word taken while both entries are occupied
  a_no_overrun: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    out_valid && skid_valid && !out_ready |=> skid_valid && $stable(skid_data));

endmodule

// File: verilog/rx_data_buffer.sv
// rx stream fifo with data, keep and last, registered output stage
// occupancy counter plus two-register delayed count toward the core
`timescale 1ns/1ps

module rx_data_buffer #(
  parameter int data_w = 512,
  parameter int depth  = 1024
) (
  input  logic                            net_clk,
  input  logic                            net_aresetn,
  input  logic                            in_valid,
  output logic                            in_ready,
  input  logic [data_w-1:0]               in_data,
  input  logic [data_w/8-1:0]             in_keep,
  input  logic                            in_last,
  output logic                            out_valid,
  input  logic                            out_ready,
  output logic [data_w-1:0]               out_data,
  output logic [data_w/8-1:0]             out_keep,
  output logic                            out_last,
  output logic [tcp_shell_pkg::cnt_w-1:0] count
);

  localparam int cw     = tcp_shell_pkg::cnt_w;
  localparam int word_w = data_w + data_w / 8 + 1;  // {last, keep, data}
  localparam int ptr_w  = (depth > 1) ? $clog2(depth) : 1;
  localparam logic [cw-1:0]    occ_full = cw'(depth);
  localparam logic [ptr_w-1:0] ptr_last = ptr_w'(depth - 1);

  logic [word_w-1:0] mem [depth];
  logic [word_w-1:0] in_word;
  logic [word_w-1:0] out_word;   // output stage
  logic [ptr_w-1:0]  wr_ptr;
  logic [ptr_w-1:0]  rd_ptr;
  logic [cw-1:0]     occ;        // words in memory plus output stage
  logic [cw-1:0]     count_d1;   // first delay stage of count
  logic              push;
  logic              pop;
  logic              load_out;   // output stage can take a word
  logic              mem_empty;
  logic              mem_rd;
  logic              mem_wr;
  logic              bypass;     // input straight to output stage

  assign in_word   = {in_last, in_keep, in_data};
  assign in_ready  = (occ != occ_full);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign load_out  = !out_valid || out_ready;
  assign mem_empty = (occ == cw'(out_valid));  // all stored words sit in the output stage
  assign mem_rd    = load_out && !mem_empty;
  assign bypass    = load_out && mem_empty && push;  // gives one-cycle latency
  assign mem_wr    = push && !bypass;

  assign out_data = out_word[data_w-1:0];
  assign out_keep = out_word[data_w+data_w/8-1:data_w];
  assign out_last = out_word[word_w-1];

  // pointers, occupancy, output valid, count pipeline
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occ       <= '0;
      out_valid <= 1'b0;
      count_d1  <= '0;
      count     <= '0;
    end else begin
      if (mem_wr) begin
        wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;  // wrap for any depth
      end
      if (mem_rd) begin
        rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
      end
      if (load_out) begin
        out_valid <= mem_rd || bypass;
      end
      occ      <= occ + cw'(push) - cw'(pop);
      count_d1 <= occ;
      count    <= count_d1;  // two registers, as the core expects
    end
  end

  // storage and output payload
  always_ff @(posedge net_clk) begin
    if (mem_wr) begin
      mem[wr_ptr] <= in_word;
    end
    if (mem_rd) begin
      out_word <= mem[rd_ptr];  // oldest stored word
    end else if (bypass) begin
      out_word <= in_word;
    end
  end

  // never more than depth words held
  a_occ_bound: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    occ <= occ_full);

  // a word leaves only when one is counted
  a_occ_floor: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    pop |-> occ != '0);

endmodule

// File: verilog/mem_cmd_port.sv
// memory command formatter, 72-bit core words to 64-bit address and 32-bit length
// counters for accepted read commands and completed read-data packets
`timescale 1ns/1ps

module mem_cmd_port (
  input  logic                                 net_clk,
  input  logic                                 net_aresetn,
  input  logic [tcp_shell_pkg::cmd_w-1:0]      rd_cmd_word,
  input  logic                                 rd_cmd_valid,
  input  logic                                 rd_cmd_ready,
  output logic [tcp_shell_pkg::mem_addr_w-1:0] rd_addr,
  output logic [tcp_shell_pkg::mem_len_w-1:0]  rd_len,
  input  logic [tcp_shell_pkg::cmd_w-1:0]      wr_cmd_word,
  input  logic                                 wr_cmd_valid,
  input  logic                                 wr_cmd_ready,
  output logic [tcp_shell_pkg::mem_addr_w-1:0] wr_addr,
  output logic [tcp_shell_pkg::mem_len_w-1:0]  wr_len,
  input  logic                                 mem_rd_valid,
  input  logic                                 mem_rd_ready,
  input  logic                                 mem_rd_last,
  output logic [tcp_shell_pkg::cnt_w-1:0]      rd_cmd_count,
  output logic [tcp_shell_pkg::cnt_w-1:0]      rd_pkg_count
);

  localparam int aw   = tcp_shell_pkg::mem_addr_w;
  localparam int lw   = tcp_shell_pkg::mem_len_w;
  localparam int a_hi = tcp_shell_pkg::cmd_addr_msb;
  localparam int a_lo = tcp_shell_pkg::cmd_addr_lsb;
  localparam int l_hi = tcp_shell_pkg::cmd_len_msb;

  logic rd_cmd_fire;  // read command handshake
  logic rd_pkg_done;  // last beat of a read packet

  // field extraction, upper command bits unused by memory
  assign rd_addr = aw'(rd_cmd_word[a_hi:a_lo]);  // zero-extended
  assign rd_len  = lw'(rd_cmd_word[l_hi:0]);
  assign wr_addr = aw'(wr_cmd_word[a_hi:a_lo]);
  assign wr_len  = lw'(wr_cmd_word[l_hi:0]);

  assign rd_cmd_fire = rd_cmd_valid && rd_cmd_ready;
  assign rd_pkg_done = mem_rd_valid && mem_rd_ready && mem_rd_last;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      rd_cmd_count <= '0;
      rd_pkg_count <= '0;
    end else begin
      if (rd_cmd_fire) begin
        rd_cmd_count <= rd_cmd_count + 1'b1;  // wraps
      end
      if (rd_pkg_done) begin
        rd_pkg_count <= rd_pkg_count + 1'b1;
      end
    end
  end

  // core keeps a stalled read command steady until memory takes it
  a_rd_cmd_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    rd_cmd_valid && !rd_cmd_ready |=> rd_cmd_valid && $stable(rd_cmd_word));

  // same for the write command
  a_wr_cmd_hold: assert property (@(posedge net_clk) disable iff (!net_aresetn)
    wr_cmd_valid && !wr_cmd_ready |=> wr_cmd_valid && $stable(wr_cmd_word));

endmodule

// File: verilog/tcp_shell.sv
// top level of the tcp offload shell
// metadata slice bank, rx data buffer, memory command port
`timescale 1ns/1ps

module tcp_shell #(
  parameter int data_w    = tcp_shell_pkg::default_data_w,
  parameter int buf_depth = tcp_shell_pkg::default_buf_depth
) (
  input  logic                                 net_clk,
  input  logic                                 net_aresetn,

  // application metadata channels, one slot per channel
  input  logic [tcp_shell_pkg::n_meta-1:0]                            meta_in_valid,
  output logic [tcp_shell_pkg::n_meta-1:0]                            meta_in_ready,
  input  logic [tcp_shell_pkg::n_meta-1:0][tcp_shell_pkg::meta_w-1:0] meta_in_data,
  output logic [tcp_shell_pkg::n_meta-1:0]                            meta_out_valid,
  input  logic [tcp_shell_pkg::n_meta-1:0]                            meta_out_ready,
  output logic [tcp_shell_pkg::n_meta-1:0][tcp_shell_pkg::meta_w-1:0] meta_out_data,

  // rx data, core into buffer
  input  logic                                 rx_in_valid,
  output logic                                 rx_in_ready,
  input  logic [data_w-1:0]                    rx_in_data,
  input  logic [data_w/8-1:0]                  rx_in_keep,
  input  logic                                 rx_in_last,

  // rx data, buffer to consumer
  output logic                                 rx_out_valid,
  input  logic                                 rx_out_ready,
  output logic [data_w-1:0]                    rx_out_data,
  output logic [data_w/8-1:0]                  rx_out_keep,
  output logic                                 rx_out_last,
  output logic [tcp_shell_pkg::cnt_w-1:0]      rx_buffer_count,

  // memory read command
  input  logic [tcp_shell_pkg::cmd_w-1:0]      rd_cmd_word,
  input  logic                                 rd_cmd_valid,
  input  logic                                 rd_cmd_ready,
  output logic [tcp_shell_pkg::mem_addr_w-1:0] rd_addr,
  output logic [tcp_shell_pkg::mem_len_w-1:0]  rd_len,

  // memory write command
  input  logic [tcp_shell_pkg::cmd_w-1:0]      wr_cmd_word,
  input  logic                                 wr_cmd_valid,
  input  logic                                 wr_cmd_ready,
  output logic [tcp_shell_pkg::mem_addr_w-1:0] wr_addr,
  output logic [tcp_shell_pkg::mem_len_w-1:0]  wr_len,

  // memory read data, observed only
  input  logic                                 mem_rd_valid,
  input  logic                                 mem_rd_ready,
  input  logic                                 mem_rd_last,

  output logic [tcp_shell_pkg::cnt_w-1:0]      rd_cmd_count,
  output logic [tcp_shell_pkg::cnt_w-1:0]      rd_pkg_count
);

  // one slice per metadata channel, breaks valid/ready paths to the core
  for (genvar i = 0; i < tcp_shell_pkg::n_meta; i++) begin : g_slice
    meta_reg_slice u_slice (
      .net_clk     (net_clk),
      .net_aresetn (net_aresetn),
      .in_valid    (meta_in_valid[i]),
      .in_ready    (meta_in_ready[i]),
      .in_data     (meta_in_data[i]),
      .out_valid   (meta_out_valid[i]),
      .out_ready   (meta_out_ready[i]),
      .out_data    (meta_out_data[i])
    );
  end

  rx_data_buffer #(
    .data_w (data_w),
    .depth  (buf_depth)
  ) u_rx_buffer (
    .net_clk     (net_clk),
    .net_aresetn (net_aresetn),
    .in_valid    (rx_in_valid),
    .in_ready    (rx_in_ready),
    .in_data     (rx_in_data),
    .in_keep     (rx_in_keep),
    .in_last     (rx_in_last),
    .out_valid   (rx_out_valid),
    .out_ready   (rx_out_ready),
    .out_data    (rx_out_data),
    .out_keep    (rx_out_keep),
    .out_last    (rx_out_last),
    .count       (rx_buffer_count)  // delayed occupancy
  );

  mem_cmd_port u_cmd_port (
    .net_clk      (net_clk),
    .net_aresetn  (net_aresetn),
    .rd_cmd_word  (rd_cmd_word),
    .rd_cmd_valid (rd_cmd_valid),
    .rd_cmd_ready (rd_cmd_ready),
    .rd_addr      (rd_addr),
    .rd_len       (rd_len),
    .wr_cmd_word  (wr_cmd_word),
    .wr_cmd_valid (wr_cmd_valid),
    .wr_cmd_ready (wr_cmd_ready),
    .wr_addr      (wr_addr),
    .wr_len       (wr_len),
    .mem_rd_valid (mem_rd_valid),
    .mem_rd_ready (mem_rd_ready),
    .mem_rd_last  (mem_rd_last),
    .rd_cmd_count (rd_cmd_count),
    .rd_pkg_count (rd_pkg_count)
  );

endmodule

// File: dv/tb_check.svh
// value compare with hex error line
// fatal stop with a plain-words reason
`ifndef TB_CHECK_SVH
`define TB_CHECK_SVH

task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
  if (got !== exp) begin
    $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    $display("TEST FAIL");
    $fatal(1, "%s mismatch", name);
  end
endtask

task automatic stop_with_failure(input string reason);
  $display("%s", reason);
  $display("TEST FAIL");
  $fatal(1, "%s", reason);
endtask

`endif

// File: dv/tb_tcp_shell.sv
// testbench top for the tcp offload shell
// random traffic on slices, rx buffer and command port, checked against queue models
`timescale 1ns/1ps

module tb_tcp_shell;

  localparam int data_w    = 64;
  localparam int buf_depth = 16;
  localparam int n_meta    = tcp_shell_pkg::n_meta;
  localparam int meta_w    = tcp_shell_pkg::meta_w;
  localparam int rx_w      = data_w + data_w / 8 + 1;  // {last, keep, data}
  localparam int n_xfer    = 1500;                     // random stimulus cycles
  localparam int cyc_limit = 4 * (n_xfer + 100);

  logic                                 net_clk = 1'b0;
  logic                                 net_aresetn;
  logic [n_meta-1:0]                    meta_in_valid, meta_in_ready;
  logic [n_meta-1:0]                    meta_out_valid, meta_out_ready;
  logic [n_meta-1:0][meta_w-1:0]        meta_in_data, meta_out_data;
  logic                                 rx_in_valid, rx_in_ready, rx_in_last;
  logic                                 rx_out_valid, rx_out_ready, rx_out_last;
  logic [data_w-1:0]                    rx_in_data, rx_out_data;
  logic [data_w/8-1:0]                  rx_in_keep, rx_out_keep;
  logic [tcp_shell_pkg::cnt_w-1:0]      rx_buffer_count, rd_cmd_count, rd_pkg_count;
  logic [tcp_shell_pkg::cmd_w-1:0]      rd_cmd_word, wr_cmd_word;
  logic                                 rd_cmd_valid, rd_cmd_ready, wr_cmd_valid, wr_cmd_ready;
  logic [tcp_shell_pkg::mem_addr_w-1:0] rd_addr, wr_addr;
  logic [tcp_shell_pkg::mem_len_w-1:0]  rd_len, wr_len;
  logic                                 mem_rd_valid, mem_rd_ready, mem_rd_last;

  int                              seed = 32'h6a99;
  int                              cyc_n = 0;           // timeout counter
  int                              step_n = 0;          // stimulus cycles so far
  logic [meta_w-1:0]               meta_q [n_meta][$];  // accepted, not yet delivered
  logic [rx_w-1:0]                 rx_q [$];            // words held by the buffer
  logic [n_meta-1:0]               meta_pend = '0;      // stalled valid, keep holding
  logic                            rx_pend = 1'b0;
  logic                            rd_pend = 1'b0;
  logic                            wr_pend = 1'b0;
  int                              occ_h1 = 0;          // model occupancy one cycle back
  int                              occ_h2 = 0;          // two cycles back
  logic [tcp_shell_pkg::cnt_w-1:0] rd_cmd_m = '0;       // read command handshakes
  logic [tcp_shell_pkg::cnt_w-1:0] rd_pkg_m = '0;       // read beats with last

  tcp_shell #(.data_w(data_w), .buf_depth(buf_depth)) DUT (.*);

  `include "tb_check.svh"

  always #4 net_clk = ~net_clk;

  always @(posedge net_clk) begin
    cyc_n <= cyc_n + 1;
    if (cyc_n > cyc_limit) begin
      stop_with_failure("simulation did not finish within the cycle limit");
    end
  end

  function automatic bit chance(input int pct);
    int r;
    r = $random(seed);
    return ((r & 32'h7fff_ffff) % 100) < pct;
  endfunction

  function automatic logic [95:0] rand96();
    return {$random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic bit drained();
    bit busy;
    busy = rx_pend || rd_pend || wr_pend || (|meta_pend) || (rx_q.size() != 0);
    for (int i = 0; i < n_meta; i++) begin
      busy = busy || (meta_q[i].size() != 0);
    end
    return !busy;
  endfunction

  // new inputs, a stalled valid keeps its word
  task automatic drive(input bit feeding);
    logic [95:0] w;
    int          out_pct;
    out_pct = feeding ? (((step_n / 100) % 2 == 0) ? 20 : 85) : 100;  // fill then drain phases
    for (int i = 0; i < n_meta; i++) begin
      if (!meta_pend[i]) begin
        w = rand96();
        meta_in_valid[i] = feeding && chance(60);
        meta_in_data[i]  = w[meta_w-1:0];
      end
      meta_out_ready[i] = chance(out_pct);
    end
    if (!rx_pend) begin
      w = rand96();
      rx_in_valid = feeding && chance(70);
      rx_in_data  = w[data_w-1:0];
      rx_in_keep  = w[rx_w-2:data_w];
      rx_in_last  = w[95];
    end
    rx_out_ready = chance(out_pct);
    if (!rd_pend) begin
      w = rand96();
      rd_cmd_valid = feeding && chance(50);
      rd_cmd_word  = w[tcp_shell_pkg::cmd_w-1:0];
    end
    if (!wr_pend) begin
      w = rand96();
      wr_cmd_valid = feeding && chance(50);
      wr_cmd_word  = w[tcp_shell_pkg::cmd_w-1:0];
    end
    rd_cmd_ready = chance(60);
    wr_cmd_ready = chance(60);
    mem_rd_valid = feeding && chance(50);
    mem_rd_ready = chance(50);
    mem_rd_last  = chance(30);
  endtask

  // compare settled outputs, then apply this cycle's transfers to the models
  task automatic check_cycle();
    logic [meta_w-1:0] meta_exp;
    logic [rx_w-1:0]   rx_exp;
    check_val("rx_in_ready", 128'(rx_in_ready), 128'(rx_q.size() != buf_depth));
    check_val("rx_buffer_count", 128'(rx_buffer_count), 128'(occ_h2));
    occ_h2 = occ_h1;
    occ_h1 = rx_q.size();  // occupancy at the start of this cycle
    check_val("rd_cmd_count", 128'(rd_cmd_count), 128'(rd_cmd_m));
    check_val("rd_pkg_count", 128'(rd_pkg_count), 128'(rd_pkg_m));
    check_val("rd_addr", 128'(rd_addr), 128'(rd_cmd_word[63:32]));  // zero-extended field
    check_val("rd_len", 128'(rd_len), 128'(rd_cmd_word[22:0]));
    check_val("wr_addr", 128'(wr_addr), 128'(wr_cmd_word[63:32]));
    check_val("wr_len", 128'(wr_len), 128'(wr_cmd_word[22:0]));
    for (int i = 0; i < n_meta; i++) begin
      if (meta_out_valid[i] && meta_out_ready[i]) begin
        if (meta_q[i].size() == 0) begin
          stop_with_failure($sformatf("slice %0d delivered a word that was never sent", i));
        end else begin
          meta_exp = meta_q[i].pop_front();
          check_val($sformatf("meta_out_data[%0d]", i), 128'(meta_out_data[i]), 128'(meta_exp));
        end
      end
      if (meta_in_valid[i] && meta_in_ready[i]) begin
        meta_q[i].push_back(meta_in_data[i]);
      end
      meta_pend[i] = meta_in_valid[i] && !meta_in_ready[i];
    end
    if (rx_out_valid && rx_out_ready) begin
      if (rx_q.size() == 0) begin
        stop_with_failure("rx buffer delivered a word that was never written");
      end else begin
        rx_exp = rx_q.pop_front();
        check_val("rx_out_data", 128'(rx_out_data), 128'(rx_exp[data_w-1:0]));
        check_val("rx_out_keep", 128'(rx_out_keep), 128'(rx_exp[rx_w-2:data_w]));
        check_val("rx_out_last", 128'(rx_out_last), 128'(rx_exp[rx_w-1]));
      end
    end
    if (rx_in_valid && rx_in_ready) begin
      rx_q.push_back({rx_in_last, rx_in_keep, rx_in_data});
    end
    rx_pend = rx_in_valid && !rx_in_ready;
    if (rd_cmd_valid && rd_cmd_ready) begin
      rd_cmd_m = rd_cmd_m + 1'b1;
    end
    if (mem_rd_valid && mem_rd_ready && mem_rd_last) begin
      rd_pkg_m = rd_pkg_m + 1'b1;
    end
    rd_pend = rd_cmd_valid && !rd_cmd_ready;
    wr_pend = wr_cmd_valid && !wr_cmd_ready;
  endtask

  task automatic run_cycle(input bit feeding);
    @(posedge net_clk);
    #1;
    drive(feeding);
    #2;
    check_cycle();
    step_n = step_n + 1;
  endtask

  initial begin
    net_aresetn = 1'b0;
    {meta_in_valid, meta_out_ready, meta_in_data} = '0;
    {rx_in_valid, rx_in_last, rx_out_ready, rx_in_data, rx_in_keep} = '0;
    {rd_cmd_word, rd_cmd_valid, rd_cmd_ready, wr_cmd_word, wr_cmd_valid, wr_cmd_ready} = '0;
    {mem_rd_valid, mem_rd_ready, mem_rd_last} = '0;
    repeat (3) @(posedge net_clk);
    #1 net_aresetn = 1'b1;
    #2;
    check_val("meta_out_valid,rx_out_valid", 128'({meta_out_valid, rx_out_valid}), 128'(0));
    check_val("meta_in_ready,rx_in_ready", 128'({meta_in_ready, rx_in_ready}),
              128'({(n_meta + 1){1'b1}}));
    check_val("rx_buffer_count,rd_cmd_count,rd_pkg_count",
              128'({rx_buffer_count, rd_cmd_count, rd_pkg_count}), 128'(0));
    repeat (n_xfer) run_cycle(1'b1);
    while (!drained()) run_cycle(1'b0);  // all readies high, stalled words finish
    @(posedge net_clk);
    #3;
    check_val("meta_out_valid", 128'(meta_out_valid), 128'(0));  // nothing extra left
    check_val("rx_out_valid", 128'(rx_out_valid), 128'(0));
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: project.f
verilog/tcp_shell_pkg.sv
verilog/meta_reg_slice.sv
verilog/rx_data_buffer.sv
verilog/mem_cmd_port.sv
verilog/tcp_shell.sv
dv/tb_tcp_shell.sv
+incdir+dv

// File: run.sh
#!/bin/sh
# compile and run the tcp shell testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_tcp_shell -f project.f
./obj_dir/Vtb_tcp_shell
